// File: include/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Datapath and address width
`define RV_XLEN 32

// Program memory depth in 32-bit words
`define RV_IMEM_WORDS 64

// Data RAM depth in 32-bit words
`define RV_DMEM_WORDS 64

// First byte address of the I/O window
`define RV_IO_BASE 32'h0000_1000

`endif

// File: rtl/RvPkg.sv
`include "rv_cfg.svh"

package RvPkg;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------

    typedef enum logic [6:0] {
        OP     = 7'b0110011,   // R-type ALU
        OP_IMM = 7'b0010011,   // ADDI
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,   // LW only
        STORE  = 7'b0100011,   // SW only
        BRANCH = 7'b1100011,   // BEQ, BLT
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcodeE;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,      // Signed compare
        PASSB     // Operand B straight through
    } aluOpE;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSelE;     // Writeback source
    typedef enum logic [1:0] {PC_PLUS4, PC_REL, PC_RS1} pcSelE;   // Next PC source

    // --------------------------------------------------
    // Buses
    // --------------------------------------------------

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;   // Fetch address
        logic [31:0]         inst;   // Returned word
    } instBusT;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wrData;
        logic                wrEn;
    } dataBusT;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] addr;   // Word address
        logic [31:0]         inst;
    } progWrT;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] addr;   // Byte address
        logic [`RV_XLEN-1:0] data;
    } ioWrT;

    typedef struct packed {
        aluOpE aluOp;
        logic  regWrEn;
        logic  memWrEn;
        logic  opASelPc;    // 1 = PC, 0 = rs1
        logic  opBSelImm;   // 1 = immediate, 0 = rs2
        wbSelE wbSel;
        pcSelE pcSel;
    } ctrlT;

endpackage

// File: rtl/InstDecoder.sv
`timescale 1ns/1ps

module InstDecoder (
    input  logic [31:0] i_inst,   // Raw instruction
    output logic [4:0]  o_rs1,
    output logic [4:0]  o_rs2,
    output logic [4:0]  o_rd,
    output logic [31:0] o_imm     // Sign-extended immediate
);

    import RvPkg::*;

    opcodeE opcode;

    assign opcode = opcodeE'(i_inst[6:0]);

    // Register fields sit in the same place for every format
    assign o_rs1 = i_inst[19:15];
    assign o_rs2 = i_inst[24:20];
    assign o_rd  = i_inst[11:7];

    // --------------------------------------------------
    // Immediate by format
    // --------------------------------------------------
    always_comb begin
        case (opcode)
            OP_IMM, LOAD, JALR: begin   // I-type
                o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
            end
            STORE: begin                // S-type
                o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            end
            BRANCH: begin               // B-type, bit 0 implied zero
                o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                         i_inst[30:25], i_inst[11:8], 1'b0};
            end
            LUI: begin                  // U-type
                o_imm = {i_inst[31:12], 12'd0};
            end
            JAL: begin                  // J-type
                o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                         i_inst[20], i_inst[30:21], 1'b0};
            end
            default: o_imm = '0;        // R-type and unknown
        endcase
    end

endmodule

// File: rtl/DatapathController.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module DatapathController (
    input  logic [31:0]         i_inst,
    input  logic [`RV_XLEN-1:0] i_rs1Data,   // For branch compare
    input  logic [`RV_XLEN-1:0] i_rs2Data,
    output RvPkg::ctrlT         o_ctrl
);

    import RvPkg::*;

    opcodeE     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       isEq;   // rs1 == rs2
    logic       isLt;   // rs1 < rs2, signed

    assign opcode = opcodeE'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    // Comparator, only branches need it
    assign isEq = (i_rs1Data == i_rs2Data);
    assign isLt = ($signed(i_rs1Data) < $signed(i_rs2Data));

    // --------------------------------------------------
    // Control word
    // --------------------------------------------------
    always_comb begin
        // Safe default behaves as a no-op
        o_ctrl = '{aluOp: ADD, regWrEn: 1'b0, memWrEn: 1'b0, opASelPc: 1'b0,
                   opBSelImm: 1'b0, wbSel: WB_ALU, pcSel: PC_PLUS4};

        case (opcode)
            OP: begin
                o_ctrl.regWrEn = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: o_ctrl.aluOp = ADD;
                    10'b0100000_000: o_ctrl.aluOp = SUB;
                    10'b0000000_111: o_ctrl.aluOp = AND;
                    10'b0000000_110: o_ctrl.aluOp = OR;
                    10'b0000000_100: o_ctrl.aluOp = XOR;
                    10'b0000000_010: o_ctrl.aluOp = SLT;
                    default:         o_ctrl.regWrEn = 1'b0;   // Outside subset
                endcase
            end
            OP_IMM: begin   // ADDI only
                o_ctrl.opBSelImm = 1'b1;
                o_ctrl.regWrEn   = (funct3 == 3'b000);
            end
            LUI: begin
                o_ctrl.aluOp     = PASSB;
                o_ctrl.opBSelImm = 1'b1;
                o_ctrl.regWrEn   = 1'b1;
            end
            LOAD: begin     // LW, address = rs1 + imm
                o_ctrl.opBSelImm = 1'b1;
                o_ctrl.wbSel     = WB_MEM;
                o_ctrl.regWrEn   = (funct3 == 3'b010);
            end
            STORE: begin    // SW
                o_ctrl.opBSelImm = 1'b1;
                o_ctrl.memWrEn   = (funct3 == 3'b010);
            end
            BRANCH: begin
                if ((funct3 == 3'b000 && isEq) || (funct3 == 3'b100 && isLt)) begin
                    o_ctrl.pcSel = PC_REL;   // BEQ / BLT taken
                end
            end
            JAL: begin
                o_ctrl.regWrEn = 1'b1;
                o_ctrl.wbSel   = WB_PC4;     // Link
                o_ctrl.pcSel   = PC_REL;
            end
            JALR: begin
                if (funct3 == 3'b000) begin
                    o_ctrl.regWrEn = 1'b1;
                    o_ctrl.wbSel   = WB_PC4;
                    o_ctrl.pcSel   = PC_RS1;
                end
            end
            default: ;      // Unknown opcode, nothing written
        endcase
    end

endmodule

// File: rtl/RegisterFile.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module RegisterFile (
    input  logic                i_Clock,
    input  logic                i_arstN,
    input  logic [4:0]          i_wrAddr,
    input  logic [`RV_XLEN-1:0] i_wrData,
    input  logic                i_wrEn,
    input  logic [4:0]          i_rdAddrA,
    output logic [`RV_XLEN-1:0] o_rdDataA,
    input  logic [4:0]          i_rdAddrB,
    output logic [`RV_XLEN-1:0] o_rdDataB
);

    logic [`RV_XLEN-1:0] regs [32];   // x0..x31

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            regs <= '{default: '0};   // All registers start at zero
        end else if (i_wrEn && i_wrAddr != 5'd0) begin
            regs[i_wrAddr] <= i_wrData;   // x0 writes dropped
        end
    end

    // Asynchronous read, x0 forced to zero
    assign o_rdDataA = (i_rdAddrA == 5'd0) ? '0 : regs[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == 5'd0) ? '0 : regs[i_rdAddrB];

endmodule

// File: rtl/IntegerAlu.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module IntegerAlu (
    input  RvPkg::aluOpE        i_op,
    input  logic [`RV_XLEN-1:0] i_operandA,
    input  logic [`RV_XLEN-1:0] i_operandB,
    output logic [`RV_XLEN-1:0] o_result
);

    import RvPkg::*;

    always_comb begin
        case (i_op)
            ADD:     o_result = i_operandA + i_operandB;
            SUB:     o_result = i_operandA - i_operandB;
            AND:     o_result = i_operandA & i_operandB;
            OR:      o_result = i_operandA | i_operandB;
            XOR:     o_result = i_operandA ^ i_operandB;
            SLT: begin   // 1 when A < B as two's complement
                o_result = {{(`RV_XLEN-1){1'b0}},
                            $signed(i_operandA) < $signed(i_operandB)};
            end
            PASSB:   o_result = i_operandB;   // LUI
            default: o_result = '0;
        endcase
    end

endmodule

// File: rtl/ProcessorSC.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module ProcessorSC (
    input  logic                i_Clock,
    input  logic                i_arstN,
    output logic [`RV_XLEN-1:0] o_instAddr,   // PC
    input  logic [31:0]         i_inst,
    output RvPkg::dataBusT      o_dBus,
    input  logic [`RV_XLEN-1:0] i_dRdData     // Load data
);

    import RvPkg::*;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pcNext;
    logic [`RV_XLEN-1:0] pcPlus4;
    logic [`RV_XLEN-1:0] pcPlusImm;   // Branch and JAL target
    logic [`RV_XLEN-1:0] rs1PlusImm;  // JALR target
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [31:0]         imm;
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;
    logic [`RV_XLEN-1:0] operandA;
    logic [`RV_XLEN-1:0] operandB;
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] wbData;
    ctrlT                ctrl;

    // --------------------------------------------------
    // Decode and control
    // --------------------------------------------------

    InstDecoder dec (
        .i_inst (i_inst),
        .o_rs1  (rs1),
        .o_rs2  (rs2),
        .o_rd   (rd),
        .o_imm  (imm));

    DatapathController dpCtrl (
        .i_inst    (i_inst),
        .i_rs1Data (rs1Data),
        .i_rs2Data (rs2Data),
        .o_ctrl    (ctrl));

    RegisterFile regs (
        .i_Clock   (i_Clock),
        .i_arstN   (i_arstN),
        .i_wrAddr  (rd),
        .i_wrData  (wbData),
        .i_wrEn    (ctrl.regWrEn),
        .i_rdAddrA (rs1),
        .o_rdDataA (rs1Data),
        .i_rdAddrB (rs2),
        .o_rdDataB (rs2Data));

    // --------------------------------------------------
    // Execute
    // --------------------------------------------------

    assign operandA = ctrl.opASelPc ? pc : rs1Data;
    assign operandB = ctrl.opBSelImm ? imm : rs2Data;

    IntegerAlu alu (
        .i_op       (ctrl.aluOp),
        .i_operandA (operandA),
        .i_operandB (operandB),
        .o_result   (aluResult));

    always_comb begin
        case (ctrl.wbSel)
            WB_MEM:  wbData = i_dRdData;   // LW
            WB_PC4:  wbData = pcPlus4;     // Return address
            default: wbData = aluResult;
        endcase
    end

    // --------------------------------------------------
    // Program counter
    // --------------------------------------------------

    assign pcPlus4    = pc + 32'd4;
    assign pcPlusImm  = pc + imm;
    assign rs1PlusImm = (rs1Data + imm) & ~32'd1;   // Bit 0 cleared

    always_comb begin
        case (ctrl.pcSel)
            PC_REL:  pcNext = pcPlusImm;
            PC_RS1:  pcNext = rs1PlusImm;
            default: pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            pc <= '0;   // Fetch starts at address 0
        end else begin
            pc <= pcNext;
        end
    end

    // Bus outputs
    assign o_instAddr    = pc;
    assign o_dBus.addr   = aluResult;
    assign o_dBus.wrData = rs2Data;
    assign o_dBus.wrEn   = ctrl.memWrEn & i_arstN;   // No stores while held in reset

endmodule

// File: rtl/ProgramMemory.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module ProgramMemory (
    input  logic                i_Clock,
    input  RvPkg::progWrT       i_progWr,   // Load strobe
    input  logic [`RV_XLEN-1:0] i_addr,     // Byte address
    output logic [31:0]         o_inst
);

    localparam int idxW = $clog2(`RV_IMEM_WORDS);

    logic [31:0]           mem [`RV_IMEM_WORDS];
    logic [`RV_XLEN-3:0]   wordIdx;

    // One word per valid cycle, out-of-range loads ignored
    always_ff @(posedge i_Clock) begin
        if (i_progWr.valid && i_progWr.addr < `RV_IMEM_WORDS) begin
            mem[i_progWr.addr[idxW-1:0]] <= i_progWr.inst;
        end
    end

    assign wordIdx = i_addr[`RV_XLEN-1:2];

    // Past the end reads zero, which decodes as a no-op
    assign o_inst = (wordIdx < `RV_IMEM_WORDS) ? mem[wordIdx[idxW-1:0]] : 32'd0;

endmodule

// File: rtl/DataMemory.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module DataMemory (
    input  logic                i_Clock,
    input  RvPkg::dataBusT      i_dBus,
    output logic [`RV_XLEN-1:0] o_rdData,
    output RvPkg::ioWrT         o_ioWr     // I/O store strobe
);

    localparam int idxW = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] ram [`RV_DMEM_WORDS];
    logic [`RV_XLEN-3:0] wordIdx;
    logic                isIo;    // Address in I/O window
    logic                inRam;   // Address backed by RAM

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    assign wordIdx = i_dBus.addr[`RV_XLEN-1:2];
    assign isIo    = (i_dBus.addr >= `RV_IO_BASE);
    assign inRam   = !isIo && (wordIdx < `RV_DMEM_WORDS);

    always_ff @(posedge i_Clock) begin
        if (i_dBus.wrEn && inRam) begin
            ram[wordIdx[idxW-1:0]] <= i_dBus.wrData;
        end
    end

    assign o_rdData = inRam ? ram[wordIdx[idxW-1:0]] : '0;   // I/O reads zero

    // High stores leave the chip for this cycle only
    assign o_ioWr.valid = i_dBus.wrEn && isIo;
    assign o_ioWr.addr  = i_dBus.addr;
    assign o_ioWr.data  = i_dBus.wrData;

endmodule

// File: rtl/RvSocTop.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module RvSocTop (
    input  logic          i_Clock,
    input  logic          i_arstN,
    input  RvPkg::progWrT i_progWr,   // Program load port
    output RvPkg::ioWrT   o_ioWr
);

    import RvPkg::*;

    instBusT             iBus;      // Fetch address out, instruction back
    dataBusT             dBus;      // Core to data memory
    logic [`RV_XLEN-1:0] dRdData;

    ProcessorSC core0 (
        .i_Clock    (i_Clock),
        .i_arstN    (i_arstN),
        .o_instAddr (iBus.addr),
        .i_inst     (iBus.inst),
        .o_dBus     (dBus),
        .i_dRdData  (dRdData));

    ProgramMemory imem (
        .i_Clock  (i_Clock),
        .i_progWr (i_progWr),
        .i_addr   (iBus.addr),
        .o_inst   (iBus.inst));

    DataMemory dmem (
        .i_Clock  (i_Clock),
        .i_dBus   (dBus),
        .o_rdData (dRdData),
        .o_ioWr   (o_ioWr));

endmodule

// File: test/tb_RvSocTop.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_RvSocTop;

    import RvPkg::*;

    localparam logic [31:0] ioBase = `RV_IO_BASE;

    logic        clock;
    logic        arstN;
    progWrT      progWr;
    ioWrT        ioWr;
    logic [31:0] prog [$];      // Program under construction
    logic [31:0] expAddr [$];   // Expected I/O strobes
    logic [31:0] expData [$];
    logic [31:0] ioAddr [$];    // Observed I/O strobes
    logic [31:0] ioData [$];
    int          errors;
    int          checks;
    int          cycleCount;
    int          totalWords;    // Sets the timeout

    RvSocTop dut0 (
        .i_Clock  (clock),
        .i_arstN  (arstN),
        .i_progWr (progWr),
        .o_ioWr   (ioWr));

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // --------------------------------------------------
    // Monitor and watchdog
    // --------------------------------------------------
    always @(posedge clock) begin
        if (ioWr.valid) begin
            if (!arstN) begin
                errors++;
                $display("ERROR: I/O strobe seen while reset was held");
            end else begin
                ioAddr.push_back(ioWr.addr);
                ioData.push_back(ioWr.data);
            end
        end
    end

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > 8 * totalWords + 20) begin   // Margin for the first reset
            $display("ERROR: run stopped after %0d cycles, program never finished",
                     cycleCount);
            reportCounts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // --------------------------------------------------
    // Instruction encoders
    // --------------------------------------------------
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] src, base, input logic [11:0] imm);
        return {imm[11:5], src, base, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    // Two's complement order, a differing sign bit decides alone
    function automatic logic [31:0] signedLess(input logic [31:0] a, b);
        return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
    endfunction

    // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        prog.push_back(lui(rd, upper[31:12]));
        prog.push_back(addi(rd, rd, value[11:0]));
    endtask

    task automatic expectIo(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // --------------------------------------------------
    // Load, run and compare
    // --------------------------------------------------
    task automatic loadProgram();
        prog.push_back(jal(5'd0, 21'd0));   // Final self-jump
        totalWords += prog.size();
        @(posedge clock);
        arstN <= 1'b0;
        ioAddr.delete();
        ioData.delete();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clock);
            progWr <= '{valid: 1'b1, addr: i, inst: prog[i]};
        end
        @(posedge clock);
        progWr <= '0;   // Last word lands here
    endtask

    task automatic runProgram();
        logic [31:0] endAddr;
        endAddr = (prog.size() - 1) * 4;
        @(posedge clock);
        arstN <= 1'b1;
        do @(negedge clock); while (dut0.core0.o_instAddr !== endAddr);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic compareIo(input string testName);
        for (int i = 0; i < expAddr.size(); i++) begin
            if (i >= ioAddr.size()) begin
                errors++;
                $display("ERROR: %s, I/O store %0d never happened", testName, i);
            end else begin
                checkValue($sformatf("%s ioWr.addr[%0d]", testName, i), ioAddr[i], expAddr[i]);
                checkValue($sformatf("%s ioWr.data[%0d]", testName, i), ioData[i], expData[i]);
            end
        end
        if (ioAddr.size() > expAddr.size()) begin
            errors++;
            $display("ERROR: %s, %0d I/O stores more than expected", testName,
                     ioAddr.size() - expAddr.size());
        end
    endtask

    task automatic startTest();
        prog.delete();
        expAddr.delete();
        expData.delete();
        prog.push_back(lui(5'd10, 20'h1));   // x10 = I/O base
    endtask

    task automatic finishTest(input string testName);
        loadProgram();
        runProgram();
        compareIo(testName);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic aluStore(input logic [6:0] f7, input logic [2:0] f3,
                            input logic [4:0] rs1, rs2, input logic [31:0] exp);
        prog.push_back(rType(f7, f3, 5'd3, rs1, rs2));
        prog.push_back(sw(5'd3, 5'd10, 12'd0));
        expectIo(ioBase, exp);
    endtask

    task automatic testAlu();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom;
        b = $urandom;
        startTest();
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        loadConst(5'd4, a | 32'h8000_0000);   // Negative
        loadConst(5'd5, b & 32'h7FFF_FFFF);   // Positive
        aluStore(7'h00, 3'b000, 5'd1, 5'd2, a + b);
        aluStore(7'h20, 3'b000, 5'd1, 5'd2, a - b);
        aluStore(7'h00, 3'b111, 5'd1, 5'd2, a & b);
        aluStore(7'h00, 3'b110, 5'd1, 5'd2, a | b);
        aluStore(7'h00, 3'b100, 5'd1, 5'd2, a ^ b);
        aluStore(7'h00, 3'b010, 5'd1, 5'd2, signedLess(a, b));
        aluStore(7'h00, 3'b010, 5'd4, 5'd5, 32'd1);   // Negative below positive
        aluStore(7'h00, 3'b010, 5'd5, 5'd4, 32'd0);
        finishTest("alu");
    endtask

    task automatic testImmediates();
        startTest();
        prog.push_back(addi(5'd1, 5'd0, 12'hFFB));   // -5
        prog.push_back(sw(5'd1, 5'd10, 12'd0));
        prog.push_back(addi(5'd2, 5'd0, 12'h800));   // -2048
        prog.push_back(sw(5'd2, 5'd10, 12'd0));
        prog.push_back(lui(5'd3, 20'hABCDE));
        prog.push_back(sw(5'd3, 5'd10, 12'd8));
        loadConst(5'd11, 32'h0000_1100);
        prog.push_back(sw(5'd1, 5'd11, 12'hFFC));    // Offset -4
        expectIo(ioBase, 32'hFFFF_FFFB);
        expectIo(ioBase, 32'hFFFF_F800);
        expectIo(ioBase + 8, 32'hABCD_E000);
        expectIo(32'h0000_10FC, 32'hFFFF_FFFB);
        finishTest("immediates");
    endtask

    task automatic testMemory();
        logic [31:0] vals [4];
        startTest();
        for (int i = 0; i < 4; i++) begin
            vals[i] = $urandom;
            loadConst(5'd1, vals[i]);
            prog.push_back(sw(5'd1, 5'd0, 12'(16 * i)));   // RAM, no strobe
        end
        for (int i = 0; i < 4; i++) begin
            prog.push_back(lw(5'd2, 5'd0, 12'(16 * i)));
            prog.push_back(sw(5'd2, 5'd10, 12'd0));
            expectIo(ioBase, vals[i]);
        end
        finishTest("memory");
    endtask

    // Branch over the first marker when taken, second marker always runs
    task automatic branchCase(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                              input logic [11:0] mark, input bit taken);
        prog.push_back(branch(f3, rs1, rs2, 13'd12));
        prog.push_back(addi(5'd5, 5'd0, mark));
        prog.push_back(sw(5'd5, 5'd10, 12'd0));
        prog.push_back(addi(5'd5, 5'd0, mark + 12'd1));
        prog.push_back(sw(5'd5, 5'd10, 12'd0));
        if (!taken) begin
            expectIo(ioBase, {20'd0, mark});
        end
        expectIo(ioBase, {20'd0, mark + 12'd1});
    endtask

    task automatic testBranches();
        startTest();
        prog.push_back(addi(5'd1, 5'd0, 12'd5));
        prog.push_back(addi(5'd2, 5'd0, 12'd5));
        prog.push_back(addi(5'd3, 5'd0, 12'hFFD));   // -3
        branchCase(3'b000, 5'd1, 5'd2, 12'h010, 1'b1);   // BEQ taken
        branchCase(3'b000, 5'd1, 5'd3, 12'h020, 1'b0);
        branchCase(3'b100, 5'd3, 5'd1, 12'h030, 1'b1);   // BLT -3 < 5
        branchCase(3'b100, 5'd1, 5'd3, 12'h040, 1'b0);
        finishTest("branches");
    endtask

    task automatic testJumps();
        logic [31:0] link;
        logic [31:0] target;
        startTest();
        link = (prog.size() + 1) * 4;
        prog.push_back(jal(5'd1, 21'd12));   // Skips two words
        prog.push_back(addi(5'd5, 5'd0, 12'h099));
        prog.push_back(sw(5'd5, 5'd10, 12'd0));
        prog.push_back(sw(5'd1, 5'd10, 12'd0));
        expectIo(ioBase, link);
        target = (prog.size() + 4) * 4;      // Index of the last store below
        link   = (prog.size() + 2) * 4;
        prog.push_back(addi(5'd6, 5'd0, target[11:0] + 12'd1));   // Odd target
        prog.push_back(jalr(5'd7, 5'd6, 12'd0));
        prog.push_back(addi(5'd5, 5'd0, 12'h098));
        prog.push_back(sw(5'd5, 5'd10, 12'd0));
        prog.push_back(sw(5'd7, 5'd10, 12'd0));
        expectIo(ioBase, link);
        finishTest("jumps");
    endtask

    task automatic testZeroReset();
        startTest();
        // I/O store at word 0, fetched by the core all through the load
        prog.push_front(sw(5'd0, 5'd0, 12'hFFC));
        expectIo(32'hFFFF_FFFC, 32'd0);
        prog.push_back(addi(5'd0, 5'd0, 12'h055));
        prog.push_back(sw(5'd0, 5'd10, 12'd0));
        prog.push_back(rType(7'h00, 3'b000, 5'd0, 5'd10, 5'd10));
        prog.push_back(sw(5'd0, 5'd10, 12'd0));
        // Written by earlier programs, cleared by this reset
        prog.push_back(sw(5'd1, 5'd10, 12'd0));
        prog.push_back(sw(5'd2, 5'd10, 12'd0));
        prog.push_back(sw(5'd3, 5'd10, 12'd0));
        prog.push_back(sw(5'd7, 5'd10, 12'd0));
        for (int i = 0; i < 6; i++) begin
            expectIo(ioBase, 32'd0);
        end
        finishTest("zero and reset");
    endtask

    task automatic reportCounts();
        $display("Checks: %0d, errors: %0d", checks, errors);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        arstN      = 1'b0;
        progWr     = '0;
        errors     = 0;
        checks     = 0;
        cycleCount = 0;
        totalWords = 0;
        void'($urandom(1498));
        repeat (10) @(posedge clock);   // First reset
        testAlu();
        testImmediates();
        testMemory();
        testBranches();
        testJumps();
        testZeroReset();
        reportCounts();
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
rtl/RvPkg.sv
rtl/InstDecoder.sv
rtl/DatapathController.sv
rtl/RegisterFile.sv
rtl/IntegerAlu.sv
rtl/ProcessorSC.sv
rtl/ProgramMemory.sv
rtl/DataMemory.sv
rtl/RvSocTop.sv
test/tb_RvSocTop.sv

// File: Bender.yml
package:
  name: rv_soc

sources:
  - include_dirs:
      - include
    files:
      - rtl/RvPkg.sv
      - rtl/InstDecoder.sv
      - rtl/DatapathController.sv
      - rtl/RegisterFile.sv
      - rtl/IntegerAlu.sv
      - rtl/ProcessorSC.sv
      - rtl/ProgramMemory.sv
      - rtl/DataMemory.sv
      - rtl/RvSocTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_RvSocTop.sv
